//--- riscv_pkg.sv
// RISC-V integer pipeline definitions
`default_nettype none

package riscv_pkg;

    // ========================================================================
    // Widths and encodings
    // ========================================================================
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;

    typedef enum logic [6:0] {
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_OP     = 7'b0110011
    } opcode_t;

    typedef enum logic [2:0] {
        FUNCT3_ADD_SUB = 3'b000,
        FUNCT3_SLT     = 3'b010,
        FUNCT3_SLTU    = 3'b011,
        FUNCT3_XOR     = 3'b100,
        FUNCT3_OR      = 3'b110,
        FUNCT3_AND     = 3'b111
    } funct3_t;

    typedef logic [6:0] funct7_t;  // Bit 5 marks SUB.

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_AND  = 4'd6
    } alu_t;

    typedef enum logic {
        OP2_RS2   = 1'b0,
        OP2_I_IMM = 1'b1
    } op2_sel_t;

    // ========================================================================
    // Instruction word
    // ========================================================================
    typedef struct packed {
        funct7_t               funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        funct3_t               funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_t               opcode;
    } r_inst_t;

    typedef struct packed {
        logic [11:0]           imm12;  // Overlays funct7 and rs2.
        logic [REG_ADDR_W-1:0] rs1;
        funct3_t               funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_t               opcode;
    } i_inst_t;

    typedef union packed {
        r_inst_t r;
        i_inst_t i;
    } inst_t;

    // ========================================================================
    // Control and stage records
    // ========================================================================
    typedef struct packed {
        logic     write;
        logic     illegal;
        alu_t     alu_op;
        op2_sel_t op2_sel;
    } ctrl_t;

    localparam ctrl_t CTRL_ILLEGAL = '{write: 1'b0, illegal: 1'b1, alu_op: ALU_ADD, op2_sel: OP2_RS2};
    localparam ctrl_t CTRL_ADDI  = '{write: 1'b1, illegal: 1'b0, alu_op: ALU_ADD, op2_sel: OP2_I_IMM};
    localparam ctrl_t CTRL_SLTI  = '{write: 1'b1, illegal: 1'b0, alu_op: ALU_SLT, op2_sel: OP2_I_IMM};
    localparam ctrl_t CTRL_SLTIU = '{write: 1'b1, illegal: 1'b0, alu_op: ALU_SLTU, op2_sel: OP2_I_IMM};
    localparam ctrl_t CTRL_XORI  = '{write: 1'b1, illegal: 1'b0, alu_op: ALU_XOR, op2_sel: OP2_I_IMM};
    localparam ctrl_t CTRL_ORI   = '{write: 1'b1, illegal: 1'b0, alu_op: ALU_OR, op2_sel: OP2_I_IMM};
    localparam ctrl_t CTRL_ANDI  = '{write: 1'b1, illegal: 1'b0, alu_op: ALU_AND, op2_sel: OP2_I_IMM};
    localparam ctrl_t CTRL_ADD   = '{write: 1'b1, illegal: 1'b0, alu_op: ALU_ADD, op2_sel: OP2_RS2};
    localparam ctrl_t CTRL_SUB   = '{write: 1'b1, illegal: 1'b0, alu_op: ALU_SUB, op2_sel: OP2_RS2};
    localparam ctrl_t CTRL_SLT   = '{write: 1'b1, illegal: 1'b0, alu_op: ALU_SLT, op2_sel: OP2_RS2};
    localparam ctrl_t CTRL_SLTU  = '{write: 1'b1, illegal: 1'b0, alu_op: ALU_SLTU, op2_sel: OP2_RS2};
    localparam ctrl_t CTRL_XOR   = '{write: 1'b1, illegal: 1'b0, alu_op: ALU_XOR, op2_sel: OP2_RS2};
    localparam ctrl_t CTRL_OR    = '{write: 1'b1, illegal: 1'b0, alu_op: ALU_OR, op2_sel: OP2_RS2};
    localparam ctrl_t CTRL_AND   = '{write: 1'b1, illegal: 1'b0, alu_op: ALU_AND, op2_sel: OP2_RS2};

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic                  illegal;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
    } ex_res_t;

    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } rf_wr_t;

endpackage

`default_nettype wire

//--- reg_file.sv
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module reg_file import riscv_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data,
    input  rf_wr_t                rf_wr
);

    logic [XLEN-1:0] regs [1:NUM_REGS-1];  // No storage for x0.

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] val;
        val = '0;
        for (int i = 1; i < NUM_REGS; i++) begin
            if (addr == REG_ADDR_W'(i)) begin
                val = regs[i];
            end
        end
        if (rf_wr.en && rf_wr.addr == addr && addr != '0) begin
            val = rf_wr.data;  // Write lands this edge.
        end
        return val;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

    always_ff @(posedge clk) begin
        for (int i = 1; i < NUM_REGS; i++) begin
            if (!resetn) begin
                regs[i] <= '0;
            end else if (rf_wr.en && rf_wr.addr == REG_ADDR_W'(i)) begin
                regs[i] <= rf_wr.data;
            end
        end
    end

endmodule

`default_nettype wire

//--- inst_decode.sv
// Instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module inst_decode import riscv_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  inst_valid,
    input  inst_t                 inst,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    input  logic [XLEN-1:0]       rs1_data,
    input  logic [XLEN-1:0]       rs2_data,
    output id_ex_t                id_ex
);

    ctrl_t           ctrl_id;
    logic [XLEN-1:0] imm;

    // ========================================================================
    // Control decode
    // ========================================================================
    always_comb begin
        unique case (inst.r.opcode)
            OPCODE_OP_IMM: begin
                unique case (inst.i.funct3)
                    FUNCT3_ADD_SUB: ctrl_id = CTRL_ADDI;
                    FUNCT3_SLT:     ctrl_id = CTRL_SLTI;
                    FUNCT3_SLTU:    ctrl_id = CTRL_SLTIU;
                    FUNCT3_XOR:     ctrl_id = CTRL_XORI;
                    FUNCT3_OR:      ctrl_id = CTRL_ORI;
                    FUNCT3_AND:     ctrl_id = CTRL_ANDI;
                    default:        ctrl_id = CTRL_ILLEGAL;  // Shifts.
                endcase
            end
            OPCODE_OP: begin
                unique case (inst.r.funct3)
                    FUNCT3_ADD_SUB: begin
                        if ((inst.r.funct7 & ~funct7_t'(7'b0100000)) != '0) begin
                            ctrl_id = CTRL_ILLEGAL;
                        end else begin
                            ctrl_id = inst.r.funct7[5] ? CTRL_SUB : CTRL_ADD;
                        end
                    end
                    FUNCT3_SLT:  ctrl_id = CTRL_SLT;
                    FUNCT3_SLTU: ctrl_id = CTRL_SLTU;
                    FUNCT3_XOR:  ctrl_id = CTRL_XOR;
                    FUNCT3_OR:   ctrl_id = CTRL_OR;
                    FUNCT3_AND:  ctrl_id = CTRL_AND;
                    default:     ctrl_id = CTRL_ILLEGAL;
                endcase
                // Only ADD/SUB may carry funct7 bits.
                if (inst.r.funct3 != FUNCT3_ADD_SUB && inst.r.funct7 != '0) begin
                    ctrl_id = CTRL_ILLEGAL;
                end
            end
            default: ctrl_id = CTRL_ILLEGAL;
        endcase
    end

    // ========================================================================
    // Operands
    // ========================================================================
    assign imm = {{(XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};  // Sign extend.
    assign rs1 = inst.r.rs1;
    assign rs2 = inst.r.rs2;

    always_ff @(posedge clk) begin
        id_ex.ctrl     <= ctrl_id;
        id_ex.rd       <= inst.r.rd;
        id_ex.rs1      <= inst.r.rs1;
        id_ex.rs2      <= inst.r.rs2;
        id_ex.rs1_data <= rs1_data;
        id_ex.rs2_data <= rs2_data;
        id_ex.imm      <= imm;
        if (!resetn) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= inst_valid;
        end
    end

endmodule

`default_nettype wire

//--- alu_execute.sv
// Execute stage with forwarding and ALU
`timescale 1ns/1ps
`default_nettype none

module alu_execute import riscv_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  id_ex_t  id_ex,
    input  rf_wr_t  fwd,
    output ex_res_t ex_res
);

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] alu_res;

    // Takes the result of the instruction one ahead when it targets src.
    function automatic logic [XLEN-1:0] fwd_mux(
        input logic [REG_ADDR_W-1:0] src,
        input logic [XLEN-1:0]       rf_data,
        input rf_wr_t                f
    );
        if (f.en && f.addr == src && src != '0) begin
            return f.data;
        end
        return rf_data;
    endfunction

    // ========================================================================
    // Operand select
    // ========================================================================
    always_comb begin
        op1     = fwd_mux(id_ex.rs1, id_ex.rs1_data, fwd);
        rs2_val = fwd_mux(id_ex.rs2, id_ex.rs2_data, fwd);
        op2     = (id_ex.ctrl.op2_sel == OP2_I_IMM) ? id_ex.imm : rs2_val;
    end

    // ========================================================================
    // ALU
    // ========================================================================
    always_comb begin
        unique case (id_ex.ctrl.alu_op)
            ALU_ADD:  alu_res = op1 + op2;
            ALU_SUB:  alu_res = op1 - op2;
            ALU_SLT:  alu_res = XLEN'($signed(op1) < $signed(op2));
            ALU_SLTU: alu_res = XLEN'(op1 < op2);
            ALU_XOR:  alu_res = op1 ^ op2;
            ALU_OR:   alu_res = op1 | op2;
            ALU_AND:  alu_res = op1 & op2;
            default:  alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        ex_res.write   <= id_ex.ctrl.write & ~id_ex.ctrl.illegal;
        ex_res.illegal <= id_ex.ctrl.illegal;
        ex_res.rd      <= id_ex.rd;
        ex_res.result  <= id_ex.ctrl.illegal ? '0 : alu_res;  // Illegal retires 0.
        if (!resetn) begin
            ex_res.valid <= 1'b0;
        end else begin
            ex_res.valid <= id_ex.valid;
        end
    end

endmodule

`default_nettype wire

//--- result_writeback.sv
// Result stage and retirement
`timescale 1ns/1ps
`default_nettype none

module result_writeback import riscv_pkg::*; (
    input  ex_res_t               ex_res,
    output rf_wr_t                rf_wr,
    output logic                  retire_valid,
    output logic [REG_ADDR_W-1:0] retire_rd,
    output logic [XLEN-1:0]       retire_data,
    output logic                  retire_illegal
);

    // ========================================================================
    // Register write
    // ========================================================================
    assign rf_wr.en = ex_res.valid
                    & ex_res.write
                    & ~ex_res.illegal
                    & (ex_res.rd != '0);  // x0 stays zero.
    assign rf_wr.addr = ex_res.rd;
    assign rf_wr.data = ex_res.result;

    // ========================================================================
    // Commit point
    // ========================================================================
    assign retire_valid   = ex_res.valid;
    assign retire_rd      = ex_res.rd;
    assign retire_data    = ex_res.result;
    assign retire_illegal = ex_res.valid & ex_res.illegal;

endmodule

`default_nettype wire

//--- int_pipe_top.sv
// Three-stage integer pipeline top
`timescale 1ns/1ps
`default_nettype none

module int_pipe_top import riscv_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  inst_valid,
    input  inst_t                 inst,
    output logic                  retire_valid,
    output logic [REG_ADDR_W-1:0] retire_rd,
    output logic [XLEN-1:0]       retire_data,
    output logic                  retire_illegal
);

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    id_ex_t                id_ex;
    ex_res_t               ex_res;
    rf_wr_t                rf_wr;  // Also the forwarding path.

    inst_decode u_decode (
        .clk        (clk),
        .resetn     (resetn),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rs1        (rs1_addr),
        .rs2        (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .id_ex      (id_ex)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .resetn   (resetn),
        .rs1      (rs1_addr),
        .rs2      (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rf_wr    (rf_wr)
    );

    alu_execute u_execute (
        .clk    (clk),
        .resetn (resetn),
        .id_ex  (id_ex),
        .fwd    (rf_wr),
        .ex_res (ex_res)
    );

    result_writeback u_result (
        .ex_res         (ex_res),
        .rf_wr          (rf_wr),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .retire_illegal (retire_illegal)
    );

endmodule

`default_nettype wire

//--- tb_int_pipe.sv
// Integer pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module tb_int_pipe import riscv_pkg::*; ;

    localparam int MAX_ROWS = 64;
    localparam int NUM_GROUPS = 6;

    typedef struct packed {
        logic [XLEN-1:0]       inst;
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        logic                  illegal;
        logic [2:0]            grp;
    } row_t;

    logic                  clk;
    logic                  resetn;
    logic                  inst_valid;
    inst_t                 inst;
    logic                  retire_valid;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic [XLEN-1:0]       retire_data;
    logic                  retire_illegal;

    row_t            rows [MAX_ROWS];
    int              num_rows = 0;
    logic [XLEN-1:0] ref_regs [NUM_REGS];
    int              grp_checks [1:NUM_GROUPS];
    int              grp_errs [1:NUM_GROUPS];
    string           grp_names [1:NUM_GROUPS];
    int              checks = 0;
    int              errors = 0;

    int_pipe_top dut (
        .clk            (clk),
        .resetn         (resetn),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .retire_illegal (retire_illegal)
    );

    always #4 clk = ~clk;  // 8 ns period.

    // ========================================================================
    // Reference model and table
    // ========================================================================
    function automatic logic [31:0] encode_r(logic [6:0] f7, logic [4:0] s2, logic [4:0] s1,
                                             logic [2:0] f3, logic [4:0] rd);
        return {f7, s2, s1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_i(logic [11:0] imm, logic [4:0] s1,
                                             logic [2:0] f3, logic [4:0] rd);
        return {imm, s1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic sub, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic add_row(input logic [31:0] w, input logic valid, input int grp);
        logic            legal;
        logic [XLEN-1:0] b;
        row_t            r;
        legal = 1'b0;
        b = '0;
        if (w[6:0] == 7'b0010011) begin
            legal = (w[14:12] != 3'b001) && (w[14:12] != 3'b101);
            b = {{20{w[31]}}, w[31:20]};
        end else if (w[6:0] == 7'b0110011) begin
            legal = (w[31:25] == 7'h00 && w[14:12] != 3'b001 && w[14:12] != 3'b101)
                 || (w[31:25] == 7'h20 && w[14:12] == 3'b000);
            b = ref_regs[w[24:20]];
        end
        r.inst = w;
        r.valid = valid;
        r.rd = w[11:7];
        r.data = legal ? alu_ref(w[14:12], w[5] & w[30], ref_regs[w[19:15]], b) : '0;
        r.illegal = !legal;
        r.grp = 3'(grp);
        rows[num_rows] = r;
        num_rows++;
        if (valid && legal && r.rd != 0) ref_regs[r.rd] = r.data;  // x0 stays zero.
    endtask

    task automatic build_table();
        for (int i = 0; i < NUM_REGS; i++) ref_regs[i] = '0;
        add_row(encode_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd5), 1'b1, 1);
        add_row(encode_i(12'hffb, 5'd0, 3'b000, 5'd1), 1'b1, 2);  // x1 = -5.
        add_row(encode_i(12'h003, 5'd1, 3'b010, 5'd3), 1'b1, 2);
        add_row(encode_i(12'h003, 5'd1, 3'b011, 5'd4), 1'b1, 2);
        for (int f = 0; f < 8; f++) begin
            if (f != 1 && f != 5) add_row(encode_i(12'($urandom), 5'd1, 3'(f), 5'(f + 2)), 1'b1, 2);
        end
        add_row(encode_i(12'($urandom), 5'd0, 3'b000, 5'd8), 1'b1, 3);
        add_row(encode_i(12'($urandom), 5'd0, 3'b000, 5'd9), 1'b1, 3);
        add_row(encode_r(7'h20, 5'd9, 5'd8, 3'b000, 5'd10), 1'b1, 3);  // SUB.
        for (int f = 0; f < 8; f++) begin
            if (f != 1 && f != 5) add_row(encode_r(7'h00, 5'd9, 5'd8, 3'(f), 5'(f + 11)), 1'b1, 3);
        end
        add_row(encode_r(7'h00, 5'd8, 5'd1, 3'b010, 5'd19), 1'b1, 3);
        add_row(encode_r(7'h00, 5'd8, 5'd1, 3'b011, 5'd20), 1'b1, 3);
        add_row(encode_i(12'd100, 5'd0, 3'b000, 5'd17), 1'b1, 4);
        add_row(encode_i(12'd1, 5'd17, 3'b000, 5'd18), 1'b1, 4);    // Distance one.
        add_row(encode_i(12'd2, 5'd17, 3'b000, 5'd21), 1'b1, 4);    // Distance two.
        add_row(encode_r(7'h00, 5'd21, 5'd18, 3'b000, 5'd22), 1'b1, 4);
        add_row(encode_r(7'h20, 5'd18, 5'd22, 3'b000, 5'd22), 1'b1, 4);
        add_row(32'h0008_8883, 1'b1, 5);                            // Load opcode, rd x17.
        add_row(encode_i(12'h001, 5'd17, 3'b001, 5'd17), 1'b1, 5);
        add_row(encode_r(7'h01, 5'd17, 5'd17, 3'b000, 5'd17), 1'b1, 5);
        add_row(encode_r(7'h20, 5'd17, 5'd17, 3'b100, 5'd17), 1'b1, 5);
        add_row(encode_i(12'd0, 5'd17, 3'b000, 5'd23), 1'b1, 5);
        add_row(encode_i(12'd55, 5'd0, 3'b000, 5'd0), 1'b1, 6);
        add_row(encode_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd24), 1'b1, 6);
        add_row(32'h0000_0000, 1'b0, 6);
        add_row(encode_i(12'd7, 5'd0, 3'b110, 5'd25), 1'b1, 6);
    endtask

    // ========================================================================
    // Checks
    // ========================================================================
    task automatic record_error(input int grp, input string msg);
        $display("ERR %0t: %s", $time, msg);
        errors++;
        grp_errs[grp]++;
    endtask

    task automatic check_row(input int idx);
        row_t r;
        r = rows[idx];
        checks++;
        grp_checks[r.grp]++;
        if (!r.valid) begin
            assert (retire_valid === 1'b0)
            else record_error(r.grp, $sformatf("row %0d: bubble produced a retirement", idx));
        end else begin
            assert (retire_valid === 1'b1 && retire_rd === r.rd && retire_data === r.data
                    && retire_illegal === r.illegal)
            else record_error(r.grp, $sformatf(
                "row %0d: got v%b rd %0d data %h ill %b, expected rd %0d data %h ill %b",
                idx, retire_valid, retire_rd, retire_data, retire_illegal,
                r.rd, r.data, r.illegal));
        end
        if (idx == num_rows - 1 || rows[idx + 1].grp != r.grp) begin
            $display("group %0d %s: %0d checks, %0d errors", r.grp, grp_names[r.grp],
                     grp_checks[r.grp], grp_errs[r.grp]);
        end
    endtask

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        void'($urandom(66483));
        grp_names = '{"reset", "i-type", "r-type", "forwarding", "illegal", "x0 and bubble"};
        for (int g = 1; g <= NUM_GROUPS; g++) begin
            grp_checks[g] = 0;
            grp_errs[g] = 0;
        end
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        checks++;
        grp_checks[1]++;
        assert (retire_valid === 1'b0 && retire_illegal === 1'b0)
        else record_error(1, "retire strobes not low after reset");
        for (int t = 0; t < num_rows + 2; t++) begin
            @(negedge clk);
            if (t >= 2) check_row(t - 2);  // Retires two cycles after issue.
            if (t < num_rows) begin
                inst_valid = rows[t].valid;
                inst = rows[t].inst;
            end else begin
                inst_valid = 1'b0;
            end
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        @(posedge resetn);
        #((num_rows + 20) * 8);
        $display("Timeout: the pipeline run did not complete in time");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
riscv_pkg.sv
reg_file.sv
inst_decode.sv
alu_execute.sv
result_writeback.sv
int_pipe_top.sv
tb_int_pipe.sv
